//--- common/gat_defines.svh
`ifndef GAT_DEFINES_SVH
`define GAT_DEFINES_SVH

// Features per Wh vector
`define GAT_FEAT_NUM 4

// Signed Wh element and attention weight
`define GAT_DATA_W 8

// Rectified coefficient, unsigned
`define GAT_SCORE_W 20

// Aggregated output feature, signed
`define GAT_ACC_W 32

// Node count, up to 15 nodes per subgraph
`define GAT_NODE_W 4

// Subgraph index, wraps
`define GAT_SG_W 4

// Buffer depth and initial credit count
`define GAT_FIFO_DEPTH 8

`endif

//--- common/gat_pkg.sv
`default_nettype none

`include "gat_defines.svh"

package gat_pkg;

  typedef logic signed [`GAT_DATA_W-1:0] data_t;
  typedef logic signed [`GAT_ACC_W-1:0]  acc_t;
  typedef logic [`GAT_SCORE_W-1:0]       score_t;
  typedef logic [`GAT_NODE_W-1:0]        node_cnt_t;
  typedef logic [`GAT_SG_W-1:0]          sg_idx_t;

  typedef data_t [`GAT_FEAT_NUM-1:0] wh_vec_t;

  // Low half weights the centre node, high half the neighbour
  typedef data_t [2*`GAT_FEAT_NUM-1:0] attn_vec_t;

  typedef struct packed {
    logic    last;
    wh_vec_t wh;
  } node_beat_t;

  typedef struct packed {
    score_t  score;
    wh_vec_t wh;
  } nbr_rec_t;

  localparam int REC_W     = $bits(nbr_rec_t);
  localparam int EOS_PAD_W = REC_W - `GAT_NODE_W - `GAT_SG_W;

  typedef struct packed {
    logic [EOS_PAD_W-1:0] pad;
    node_cnt_t            node_cnt;
    sg_idx_t              sg_idx;
  } end_rec_t;

  // Same buffer word, read as neighbour or end-of-subgraph record
  typedef union packed {
    nbr_rec_t nbr;
    end_rec_t eos;
  } rec_u;

  typedef struct packed {
    logic is_end;
    rec_u rec;
  } fifo_word_t;

  typedef struct packed {
    acc_t [`GAT_FEAT_NUM-1:0] feat;
    node_cnt_t                node_cnt;
    sg_idx_t                  sg_idx;
  } feat_out_t;

endpackage

`default_nettype wire

//--- rtl/attn_score.sv
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module attn_score
  import gat_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  attn_vec_t  attn_i,
  input  node_beat_t node_i,
  input  logic       node_vld_i,
  output logic       node_rdy_o,
  input  logic       credit_i,
  output fifo_word_t wr_word_o,
  output logic       wr_en_o
);

  localparam int FEAT_NUM = `GAT_FEAT_NUM;
  localparam int DOT_W    = 2 * `GAT_DATA_W + $clog2(`GAT_FEAT_NUM);
  localparam int SUM_W    = DOT_W + 1;
  localparam int CRED_W   = $clog2(`GAT_FIFO_DEPTH + 1);

  typedef logic signed [DOT_W-1:0] dot_t;
  typedef logic signed [SUM_W-1:0] sum_t;

  logic [CRED_W-1:0] credit_q;
  logic [CRED_W-1:0] credit_take;
  logic              accept;
  logic              first_q;
  logic              s1_vld;
  logic              s1_last;
  wh_vec_t           s1_wh;
  dot_t              s1_ctr;
  dot_t              s1_nbr;
  sum_t              sum;
  score_t            score;
  logic              end_pend;
  node_cnt_t         node_cnt_q;
  sg_idx_t           sg_idx_q;

  function automatic dot_t dot(input wh_vec_t wh, input attn_vec_t attn, input int base);
    dot_t acc;
    acc = '0;
    for (int k = 0; k < FEAT_NUM; k++) begin
      acc = acc + wh[k] * attn[base + k];
    end
    return acc;
  endfunction

  assign accept = node_vld_i && node_rdy_o;

  // A last beat reserves a second slot for its end record
  assign credit_take = !accept ? '0 : (node_i.last ? CRED_W'(2) : CRED_W'(1));

  // Hold off one cycle after a last beat so the end record gets the write slot
  assign node_rdy_o = (credit_q >= CRED_W'(2)) && !(s1_vld && s1_last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q <= CRED_W'(`GAT_FIFO_DEPTH);
      first_q  <= 1'b1;
      s1_vld   <= 1'b0;
      s1_last  <= 1'b0;
    end else begin
      credit_q <= credit_q - credit_take + CRED_W'(credit_i);
      s1_vld   <= accept;
      if (accept) begin
        first_q <= node_i.last;
        s1_last <= node_i.last;
      end
    end
  end

  // Stage 1 dot products
  always_ff @(posedge clk) begin
    if (accept) begin
      s1_wh  <= node_i.wh;
      s1_nbr <= dot(node_i.wh, attn_i, FEAT_NUM);
      // Centre term stays until the next subgraph starts
      if (first_q) begin
        s1_ctr <= dot(node_i.wh, attn_i, 0);
      end
    end
  end

  assign sum   = s1_ctr + s1_nbr;
  assign score = sum[SUM_W-1] ? '0 : score_t'(sum);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_en_o    <= 1'b0;
      end_pend   <= 1'b0;
      node_cnt_q <= '0;
      sg_idx_q   <= '0;
    end else if (end_pend) begin
      wr_en_o    <= 1'b1;
      end_pend   <= 1'b0;
      node_cnt_q <= '0;
      sg_idx_q   <= sg_idx_q + 1'b1;
    end else begin
      wr_en_o <= s1_vld;
      if (s1_vld) begin
        end_pend   <= s1_last;
        node_cnt_q <= node_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (end_pend) begin
      wr_word_o.is_end           <= 1'b1;
      wr_word_o.rec.eos.pad      <= '0;
      wr_word_o.rec.eos.node_cnt <= node_cnt_q;
      wr_word_o.rec.eos.sg_idx   <= sg_idx_q;
    end else if (s1_vld) begin
      wr_word_o.is_end        <= 1'b0;
      wr_word_o.rec.nbr.score <= score;
      wr_word_o.rec.nbr.wh    <= s1_wh;
    end
  end

endmodule

`default_nettype wire

//--- rtl/coef_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module coef_fifo
  import gat_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  fifo_word_t wr_word_i,
  input  logic       wr_en_i,
  output fifo_word_t rd_word_o,
  output logic       rd_vld_o,
  input  logic       rd_en_i,
  output logic       credit_o
);

  localparam int DEPTH = `GAT_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  fifo_word_t    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          pop;

  function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign rd_vld_o  = (count != '0);
  assign rd_word_o = mem[rd_ptr];
  assign pop       = rd_en_i && rd_vld_o;

  // Writer never exceeds its credits, so no full check here
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_ptr] <= wr_word_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_o <= 1'b0;
    end else begin
      if (wr_en_i) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      count    <= count + CW'(wr_en_i) - CW'(pop);
      // One credit back per word popped
      credit_o <= pop;
    end
  end

endmodule

`default_nettype wire

//--- rtl/aggregator.sv
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module aggregator
  import gat_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  fifo_word_t rd_word_i,
  input  logic       rd_vld_i,
  output logic       rd_en_o,
  output feat_out_t  feat_o,
  output logic       feat_vld_o,
  input  logic       feat_rdy_i
);

  localparam int FEAT_NUM = `GAT_FEAT_NUM;

  acc_t [FEAT_NUM-1:0] acc_q;
  logic                pop_nbr;
  logic                pop_end;
  logic                stall;

  // A result waiting on the output blocks further pops
  assign stall   = feat_vld_o && !feat_rdy_i;
  assign rd_en_o = rd_vld_i && !stall;
  assign pop_nbr = rd_en_o && !rd_word_i.is_end;
  assign pop_end = rd_en_o && rd_word_i.is_end;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q      <= '0;
      feat_vld_o <= 1'b0;
    end else if (pop_end) begin
      acc_q      <= '0;
      feat_vld_o <= 1'b1;
    end else begin
      if (feat_rdy_i) begin
        feat_vld_o <= 1'b0;
      end
      if (pop_nbr) begin
        for (int k = 0; k < FEAT_NUM; k++) begin
          // Score is unsigned, widen before the signed multiply
          acc_q[k] <= acc_q[k]
                    + $signed({1'b0, rd_word_i.rec.nbr.score}) * rd_word_i.rec.nbr.wh[k];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop_end) begin
      feat_o.feat     <= acc_q;
      feat_o.node_cnt <= rd_word_i.rec.eos.node_cnt;
      feat_o.sg_idx   <= rd_word_i.rec.eos.sg_idx;
    end
  end

endmodule

`default_nettype wire

//--- rtl/gat_layer.sv
`timescale 1ns/1ps
`default_nettype none

module gat_layer
  import gat_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  attn_vec_t  attn_i,
  input  node_beat_t node_i,
  input  logic       node_vld_i,
  output logic       node_rdy_o,
  output feat_out_t  feat_o,
  output logic       feat_vld_o,
  input  logic       feat_rdy_i
);

  fifo_word_t wr_word;
  logic       wr_en;
  fifo_word_t rd_word;
  logic       rd_vld;
  logic       rd_en;
  logic       credit;

  attn_score u_attn_score (
    .clk        (clk),
    .rst_n      (rst_n),
    .attn_i     (attn_i),
    .node_i     (node_i),
    .node_vld_i (node_vld_i),
    .node_rdy_o (node_rdy_o),
    .credit_i   (credit),
    .wr_word_o  (wr_word),
    .wr_en_o    (wr_en)
  );

  coef_fifo u_coef_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_word_i (wr_word),
    .wr_en_i   (wr_en),
    .rd_word_o (rd_word),
    .rd_vld_o  (rd_vld),
    .rd_en_i   (rd_en),
    .credit_o  (credit)
  );

  aggregator u_aggregator (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_word_i  (rd_word),
    .rd_vld_i   (rd_vld),
    .rd_en_o    (rd_en),
    .feat_o     (feat_o),
    .feat_vld_o (feat_vld_o),
    .feat_rdy_i (feat_rdy_i)
  );

endmodule

`default_nettype wire

//--- tests/gat_model.svh
`ifndef GAT_MODEL_SVH
`define GAT_MODEL_SVH

`include "gat_defines.svh"

localparam int MAX_NODES = (1 << `GAT_NODE_W) - 1;

// Dot product of a Wh vector with the low or high attention half
function automatic int half_dot(input wh_vec_t wh, input attn_vec_t attn, input bit high);
  int sum;
  int base;
  sum = 0;
  base = high ? `GAT_FEAT_NUM : 0;
  for (int k = 0; k < `GAT_FEAT_NUM; k++) begin
    sum = sum + int'(wh[k]) * int'(attn[base + k]);
  end
  return sum;
endfunction

// Centre term plus neighbour term, negatives clipped to zero
function automatic int node_score(input wh_vec_t ctr, input wh_vec_t wh,
                                  input attn_vec_t attn);
  int raw;
  raw = half_dot(ctr, attn, 1'b0) + half_dot(wh, attn, 1'b1);
  return (raw < 0) ? 0 : raw;
endfunction

function automatic feat_out_t expected_feat(input wh_vec_t nodes [MAX_NODES], input int n,
                                            input attn_vec_t attn, input sg_idx_t sg);
  feat_out_t res;
  int score;
  res = '0;
  for (int i = 0; i < n; i++) begin
    // First beat is the centre and counts as its own neighbour
    score = node_score(nodes[0], nodes[i], attn);
    for (int k = 0; k < `GAT_FEAT_NUM; k++) begin
      res.feat[k] = res.feat[k] + acc_t'(score * int'(nodes[i][k]));
    end
  end
  res.node_cnt = node_cnt_t'(n);
  res.sg_idx   = sg;
  return res;
endfunction

`endif

//--- tests/gat_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "gat_defines.svh"

module gat_layer_tb
  import gat_pkg::*;
();

  logic       clk;
  logic       rst_n;
  attn_vec_t  attn;
  node_beat_t node_i;
  logic       node_vld_i;
  logic       node_rdy_o;
  feat_out_t  feat_o;
  logic       feat_vld_o;
  logic       feat_rdy_i;

  feat_out_t exp_q [$];
  int        errors = 0;
  int        checks = 0;
  int        results = 0;
  int        nodes_sent = 0;
  int        rdy_mode = 0;
  logic      saw_rdy_low = 1'b0;
  sg_idx_t   sg_next = '0;

  `include "gat_model.svh"

  gat_layer UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .attn_i     (attn),
    .node_i     (node_i),
    .node_vld_i (node_vld_i),
    .node_rdy_o (node_rdy_o),
    .feat_o     (feat_o),
    .feat_vld_o (feat_vld_o),
    .feat_rdy_i (feat_rdy_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  reset_state: assert property (@(posedge clk) !rst_n |-> (!feat_vld_o && node_rdy_o))
    else begin
      errors++;
      $display("mismatch at %0t: outputs not in reset state", $time);
    end

  task automatic check_reset_state();
    checks++;
    assert (!feat_vld_o && node_rdy_o) else begin
      errors++;
      $display("mismatch at %0t: feat_vld_o=%0b node_rdy_o=%0b around reset",
               $time, feat_vld_o, node_rdy_o);
    end
  endtask

  // Holds the beat until a rising edge sees ready high
  task automatic send_beat(input node_beat_t beat);
    logic taken;
    node_i     = beat;
    node_vld_i = 1'b1;
    nodes_sent++;
    do begin
      @(negedge clk);
      taken = node_rdy_o;
      @(posedge clk);
      #1;
    end while (!taken);
    node_vld_i = 1'b0;
  endtask

  task automatic send_subgraph(input int n, input bit clip);
    wh_vec_t    nodes [MAX_NODES];
    node_beat_t beat;
    int         mag;
    int         gap;
    for (int i = 0; i < n; i++) begin
      for (int k = 0; k < `GAT_FEAT_NUM; k++) begin
        mag = $urandom_range(127, 1);
        if (clip) begin
          // Opposite sign to both attention halves, so every score is negative
          nodes[i][k] = (attn[k] < 0) ? data_t'(mag) : data_t'(-mag);
        end else begin
          nodes[i][k] = data_t'($urandom_range(255, 0));
        end
      end
    end
    exp_q.push_back(expected_feat(nodes, n, attn, sg_next));
    sg_next = sg_next + 1'b1;
    for (int i = 0; i < n; i++) begin
      beat.last = (i == n - 1);
      beat.wh   = nodes[i];
      send_beat(beat);
      gap = $urandom_range(2, 0);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  initial begin : drive_ready
    int mode;
    feat_rdy_i = 1'b1;
    forever begin
      @(posedge clk);
      mode = rdy_mode;
      #1;
      case (mode)
        1:       feat_rdy_i = ($urandom_range(3, 0) != 0);
        2:       feat_rdy_i = 1'b0;
        default: feat_rdy_i = 1'b1;
      endcase
    end
  end

  initial begin : output_monitor
    feat_out_t want;
    feat_out_t held_feat;
    logic      held_prev;
    int        held_beats;
    held_prev  = 1'b0;
    held_feat  = '0;
    held_beats = 0;
    forever begin
      @(negedge clk);
      if (held_prev) begin
        checks++;
        assert (feat_vld_o && feat_o == held_feat) else begin
          errors++;
          $display("mismatch at %0t: held result changed before it was accepted", $time);
        end
      end
      if (feat_vld_o && feat_rdy_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Result at %0t arrived with no subgraph outstanding", $time);
        end else begin
          want = exp_q.pop_front();
          checks++;
          results++;
          assert (feat_o == want) else begin
            errors++;
            $display("mismatch at %0t: sg %0d cnt %0d feat %h, expected sg %0d cnt %0d feat %h",
                     $time, feat_o.sg_idx, feat_o.node_cnt, feat_o.feat,
                     want.sg_idx, want.node_cnt, want.feat);
          end
        end
      end
      held_prev = feat_vld_o && !feat_rdy_i;
      held_feat = feat_o;
      if (held_prev && node_vld_i && node_rdy_o) begin
        held_beats++;
        checks++;
        assert (held_beats <= `GAT_FIFO_DEPTH) else begin
          errors++;
          $display("Input still accepted %0d beats past a held result at %0t", held_beats, $time);
        end
      end else if (!held_prev) begin
        held_beats = 0;
      end
      if (held_prev && !node_rdy_o) begin
        saw_rdy_low = 1'b1;
      end
    end
  end

  // Limit grows with the number of nodes driven so far
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 40 * nodes_sent + 2000) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
    $display("Closing report: %0d checks, %0d errors, %0d results", checks, errors, results);
    $display("Checks failed");
    $finish;
  end

  initial begin : stimulus
    int  mag;
    bit  neg;
    void'($urandom(81642));
    rst_n      = 1'b1;
    node_i     = '0;
    node_vld_i = 1'b0;
    // Both halves share a sign per feature
    for (int k = 0; k < `GAT_FEAT_NUM; k++) begin
      neg = $urandom_range(1, 0);
      mag = $urandom_range(40, 1);
      attn[k] = neg ? data_t'(-mag) : data_t'(mag);
      mag = $urandom_range(40, 1);
      attn[k + `GAT_FEAT_NUM] = neg ? data_t'(-mag) : data_t'(mag);
    end
    // Falling edge on rst_n fires the asynchronous reset
    #1;
    rst_n = 1'b0;
    repeat (3) begin
      @(posedge clk);
      #1;
      check_reset_state();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    @(posedge clk);
    #1;
    for (int s = 0; s < 16; s++) begin
      send_subgraph($urandom_range(6, 1), (s % 4) == 3);
    end
    rdy_mode = 1;
    for (int s = 0; s < 16; s++) begin
      send_subgraph($urandom_range(6, 1), (s % 5) == 4);
    end
    rdy_mode = 2;
    saw_rdy_low = 1'b0;
    fork
      for (int s = 0; s < 4; s++) begin
        send_subgraph(5, 1'b0);
      end
      begin
        repeat (120) @(posedge clk);
        #1;
        checks++;
        assert (saw_rdy_low) else begin
          errors++;
          $display("node_rdy_o never fell while the output was held");
        end
        rdy_mode = 0;
      end
    join
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);
    $display("Closing report: %0d checks, %0d errors, %0d results", checks, errors, results);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- gat_layer.f
+incdir+common
+incdir+tests
common/gat_pkg.sv
rtl/attn_score.sv
rtl/coef_fifo.sv
rtl/aggregator.sv
rtl/gat_layer.sv
tests/gat_layer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the gat_layer testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=gat_layer_sim
PASS_MSG="All checks passed"

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module gat_layer_tb --Mdir "$BUILD_DIR" -o "$SIM_BIN" -f gat_layer.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

sim_out=$("./$BUILD_DIR/$SIM_BIN")
status=$?
echo "$sim_out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only if the testbench printed its pass line
if echo "$sim_out" | grep -qx "$PASS_MSG"; then
  echo "Simulation result: PASS"
  exit 0
fi
echo "Simulation result: FAIL"
exit 1
